// ==== verilog/comdecomp_defines.svh ====
`ifndef COMDECOMP_DEFINES_SVH
`define COMDECOMP_DEFINES_SVH

// bits per beat
`define DATA_WIDTH 64

// beats per page, 16 x 64 bits is a 128 byte page
`define PAGE_BEATS 16

// largest non-zero beat count that still compresses
`define COMP_LIMIT 12

// width of the compressed byte count
`define SIZE_WIDTH 14

// bytes per beat
`define BEAT_BYTES 8

`endif

// ==== verilog/comdecomp_pkg.sv ====
`include "comdecomp_defines.svh"

package comdecomp_pkg;

    // position inside a page
    localparam int IDX_WIDTH = $clog2(`PAGE_BEATS);
    // holds a count of 0 up to PAGE_BEATS + 1
    localparam int CNT_WIDTH = $clog2(`PAGE_BEATS + 2);

    typedef enum logic [2:0] {
        COMP_IDLE,
        COMP_SCAN,
        COMP_REWIND,
        COMP_HEADER,
        COMP_COPY,
        COMP_DONE
    } comp_state_e;

    typedef enum logic [2:0] {
        DECOMP_IDLE,
        DECOMP_HEADER,
        DECOMP_EXPAND,
        DECOMP_RAW,
        DECOMP_DONE
    } decomp_state_e;

    typedef struct packed {
        comp_state_e            state;
        logic [IDX_WIDTH-1:0]   beat_idx;
        logic [CNT_WIDTH-1:0]   nz_count;
        logic [`PAGE_BEATS-1:0] bitmap;
    } debug_compressor;

    typedef struct packed {
        decomp_state_e          state;
        logic [IDX_WIDTH-1:0]   beat_idx;
        logic [`PAGE_BEATS-1:0] bitmap;
    } debug_decompressor;

endpackage

// ==== verilog/comdecomp_if.sv ====
`include "comdecomp_defines.svh"

// show-ahead read FIFO port, rd_data is the head whenever rd_valid is high
interface rd_port_if;
    logic                   rready;
    logic [`DATA_WIDTH-1:0] rd_data;
    logic                   rd_valid;
    logic                   rdfifo_empty;
    logic                   ld_rdfifo_rdptr;

    modport engine (
        output rready,
        output ld_rdfifo_rdptr,
        input  rd_data,
        input  rd_valid,
        input  rdfifo_empty
    );

    modport fifo (
        input  rready,
        input  ld_rdfifo_rdptr,
        output rd_data,
        output rd_valid,
        output rdfifo_empty
    );
endinterface

// write FIFO port, one beat per cycle with wr_req high
interface wr_port_if;
    logic                   wr_req;
    logic [`DATA_WIDTH-1:0] wr_data;
    logic                   wrfifo_full;

    modport engine (
        output wr_req,
        output wr_data,
        input  wrfifo_full
    );

    modport fifo (
        input  wr_req,
        input  wr_data,
        output wrfifo_full
    );
endinterface

// ==== verilog/page_compressor.sv ====
`include "comdecomp_defines.svh"

module page_compressor (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           comp_start,
    rd_port_if.engine                      rd,
    wr_port_if.engine                      wr,
    output logic [`SIZE_WIDTH-1:0]         comp_size,
    output logic                           incompressible,
    output logic                           comp_done,
    output comdecomp_pkg::debug_compressor debug_comp
);

    localparam int IW = comdecomp_pkg::IDX_WIDTH;
    localparam int CW = comdecomp_pkg::CNT_WIDTH;

    comdecomp_pkg::comp_state_e state;
    logic [IW-1:0]          beat_idx;
    logic [CW-1:0]          nz_count;
    logic [CW-1:0]          nz_next;
    logic [CW-1:0]          wr_count;
    logic [`PAGE_BEATS-1:0] bitmap;
    logic                   rd_avail;
    logic                   beat_nz;
    logic                   need_wr;
    logic                   last_beat;

    assign rd_avail  = rd.rd_valid && !rd.rdfifo_empty;
    assign beat_nz   = |rd.rd_data;
    assign nz_next   = nz_count + CW'(beat_nz);
    assign last_beat = (beat_idx == IW'(`PAGE_BEATS - 1));

    // raw pages write every beat, compressed pages only the marked ones
    assign need_wr = incompressible || bitmap[beat_idx];

    assign comp_size = `SIZE_WIDTH'(wr_count) * `SIZE_WIDTH'(`BEAT_BYTES);

    always_comb begin
        rd.rready          = 1'b0;
        rd.ld_rdfifo_rdptr = 1'b0;
        wr.wr_req          = 1'b0;
        wr.wr_data         = rd.rd_data;
        case (state)
            comdecomp_pkg::COMP_SCAN: begin
                rd.rready = rd_avail;
            end
            comdecomp_pkg::COMP_REWIND: begin
                rd.ld_rdfifo_rdptr = 1'b1;
            end
            comdecomp_pkg::COMP_HEADER: begin
                wr.wr_req  = !wr.wrfifo_full;
                wr.wr_data = `DATA_WIDTH'(bitmap);
            end
            comdecomp_pkg::COMP_COPY: begin
                // zero beats are dropped, so they need no room in the write FIFO
                rd.rready = rd_avail && (!need_wr || !wr.wrfifo_full);
                wr.wr_req = rd_avail && need_wr && !wr.wrfifo_full;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state          <= comdecomp_pkg::COMP_IDLE;
            beat_idx       <= '0;
            nz_count       <= '0;
            wr_count       <= '0;
            bitmap         <= '0;
            incompressible <= 1'b0;
            comp_done      <= 1'b0;
        end else begin
            comp_done <= 1'b0;
            if (wr.wr_req) begin
                wr_count <= wr_count + 1'b1;
            end
            case (state)
                comdecomp_pkg::COMP_IDLE: begin
                    if (comp_start) begin
                        state          <= comdecomp_pkg::COMP_SCAN;
                        beat_idx       <= '0;
                        nz_count       <= '0;
                        wr_count       <= '0;
                        bitmap         <= '0;
                        incompressible <= 1'b0;
                    end
                end
                comdecomp_pkg::COMP_SCAN: begin
                    if (rd.rready) begin
                        bitmap[beat_idx] <= beat_nz;
                        nz_count         <= nz_next;
                        beat_idx         <= beat_idx + 1'b1;
                        if (last_beat) begin
                            state          <= comdecomp_pkg::COMP_REWIND;
                            incompressible <= (nz_next > CW'(`COMP_LIMIT));
                        end
                    end
                end
                comdecomp_pkg::COMP_REWIND: begin
                    beat_idx <= '0;
                    state    <= incompressible ? comdecomp_pkg::COMP_COPY
                                               : comdecomp_pkg::COMP_HEADER;
                end
                comdecomp_pkg::COMP_HEADER: begin
                    if (wr.wr_req) begin
                        state <= comdecomp_pkg::COMP_COPY;
                    end
                end
                comdecomp_pkg::COMP_COPY: begin
                    if (rd.rready) begin
                        beat_idx <= beat_idx + 1'b1;
                        if (last_beat) begin
                            state     <= comdecomp_pkg::COMP_DONE;
                            comp_done <= 1'b1;
                        end
                    end
                end
                default: begin
                    // hold here until the start level drops
                    if (!comp_start) begin
                        state <= comdecomp_pkg::COMP_IDLE;
                    end
                end
            endcase
        end
    end

    assign debug_comp = '{state: state, beat_idx: beat_idx, nz_count: nz_count,
                          bitmap: bitmap};

    a_no_wr_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
        wr.wrfifo_full |-> !wr.wr_req);

    // no read in the rewind cycle
    a_rewind_no_read: assert property (@(posedge clk_i) disable iff (rst_i)
        !(rd.ld_rdfifo_rdptr && rd.rready));

endmodule

// ==== verilog/page_decompressor.sv ====
`include "comdecomp_defines.svh"

module page_decompressor (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             decomp_start,
    input  logic                             decomp_raw,
    rd_port_if.engine                        rd,
    wr_port_if.engine                        wr,
    output logic                             decomp_done,
    output comdecomp_pkg::debug_decompressor debug_decomp
);

    localparam int IW = comdecomp_pkg::IDX_WIDTH;

    comdecomp_pkg::decomp_state_e state;
    logic [IW-1:0]          beat_idx;
    logic [`PAGE_BEATS-1:0] bitmap;
    logic                   rd_avail;
    logic                   last_beat;

    assign rd_avail  = rd.rd_valid && !rd.rdfifo_empty;
    assign last_beat = (beat_idx == IW'(`PAGE_BEATS - 1));

    // the source stream is always read from its start
    assign rd.ld_rdfifo_rdptr = 1'b0;

    always_comb begin
        rd.rready  = 1'b0;
        wr.wr_req  = 1'b0;
        wr.wr_data = rd.rd_data;
        case (state)
            comdecomp_pkg::DECOMP_HEADER: begin
                rd.rready = rd_avail;
            end
            comdecomp_pkg::DECOMP_EXPAND: begin
                if (bitmap[beat_idx]) begin
                    rd.rready = rd_avail && !wr.wrfifo_full;
                    wr.wr_req = rd_avail && !wr.wrfifo_full;
                end else begin
                    // zero beat rebuilt without touching the read side
                    wr.wr_req  = !wr.wrfifo_full;
                    wr.wr_data = '0;
                end
            end
            comdecomp_pkg::DECOMP_RAW: begin
                rd.rready = rd_avail && !wr.wrfifo_full;
                wr.wr_req = rd_avail && !wr.wrfifo_full;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state       <= comdecomp_pkg::DECOMP_IDLE;
            beat_idx    <= '0;
            bitmap      <= '0;
            decomp_done <= 1'b0;
        end else begin
            decomp_done <= 1'b0;
            case (state)
                comdecomp_pkg::DECOMP_IDLE: begin
                    if (decomp_start) begin
                        beat_idx <= '0;
                        state    <= decomp_raw ? comdecomp_pkg::DECOMP_RAW
                                               : comdecomp_pkg::DECOMP_HEADER;
                    end
                end
                comdecomp_pkg::DECOMP_HEADER: begin
                    if (rd.rready) begin
                        bitmap <= rd.rd_data[`PAGE_BEATS-1:0];
                        state  <= comdecomp_pkg::DECOMP_EXPAND;
                    end
                end
                comdecomp_pkg::DECOMP_EXPAND, comdecomp_pkg::DECOMP_RAW: begin
                    if (wr.wr_req) begin
                        beat_idx <= beat_idx + 1'b1;
                        if (last_beat) begin
                            state       <= comdecomp_pkg::DECOMP_DONE;
                            decomp_done <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (!decomp_start) begin
                        state <= comdecomp_pkg::DECOMP_IDLE;
                    end
                end
            endcase
        end
    end

    assign debug_decomp = '{state: state, beat_idx: beat_idx, bitmap: bitmap};

    a_no_wr_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
        wr.wrfifo_full |-> !wr.wr_req);

endmodule

// ==== verilog/comdecomp_unit.sv ====
`include "comdecomp_defines.svh"

module comdecomp_unit (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             comp_start,
    input  logic                             decomp_start,
    input  logic                             decomp_raw,
    input  logic                             rdfifo_empty,
    input  logic [`DATA_WIDTH-1:0]           rd_data,
    input  logic                             rd_valid,
    input  logic                             wrfifo_full,
    output logic [`SIZE_WIDTH-1:0]           comp_size,
    output logic                             comp_done,
    output logic                             decomp_done,
    output logic                             incompressible,
    output logic                             rready,
    output logic                             ld_rdfifo_rdptr,
    output logic                             wr_req,
    output logic [`DATA_WIDTH-1:0]           wr_data,
    output comdecomp_pkg::debug_compressor   debug_comp,
    output comdecomp_pkg::debug_decompressor debug_decomp
);

    rd_port_if comp_rd ();
    wr_port_if comp_wr ();
    rd_port_if decomp_rd ();
    wr_port_if decomp_wr ();

    // FIFO status goes to both engines, only the selected one acts on it
    assign comp_rd.rd_data        = rd_data;
    assign comp_rd.rd_valid       = rd_valid;
    assign comp_rd.rdfifo_empty   = rdfifo_empty;
    assign comp_wr.wrfifo_full    = wrfifo_full;
    assign decomp_rd.rd_data      = rd_data;
    assign decomp_rd.rd_valid     = rd_valid;
    assign decomp_rd.rdfifo_empty = rdfifo_empty;
    assign decomp_wr.wrfifo_full  = wrfifo_full;

    assign rready          = decomp_start ? decomp_rd.rready : comp_rd.rready;
    assign ld_rdfifo_rdptr = decomp_start ? decomp_rd.ld_rdfifo_rdptr : comp_rd.ld_rdfifo_rdptr;
    assign wr_req          = decomp_start ? decomp_wr.wr_req : comp_wr.wr_req;
    assign wr_data         = decomp_start ? decomp_wr.wr_data : comp_wr.wr_data;

    page_compressor i_page_compressor (
        .clk_i,
        .rst_i,
        .comp_start,
        .rd (comp_rd.engine),
        .wr (comp_wr.engine),
        .comp_size,
        .incompressible,
        .comp_done,
        .debug_comp
    );

    page_decompressor i_page_decompressor (
        .clk_i,
        .rst_i,
        .decomp_start,
        .decomp_raw,
        .rd (decomp_rd.engine),
        .wr (decomp_wr.engine),
        .decomp_done,
        .debug_decomp
    );

    a_one_engine: assert property (@(posedge clk_i) disable iff (rst_i)
        !(comp_start && decomp_start));

endmodule

// ==== sim/tb_comdecomp.sv ====
`include "comdecomp_defines.svh"

module tb_comdecomp;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PB = `PAGE_BEATS;
    localparam int DW = `DATA_WIDTH;
    localparam int MAX_BEATS = 2 * PB;
    // four compressions and two decompressions of one page each
    localparam int TOTAL_BEATS = 6 * PB;
    localparam int CYCLE_LIMIT = 8 * TOTAL_BEATS * 4;

    logic                             clk_i;
    logic                             rst_i;
    logic                             comp_start;
    logic                             decomp_start;
    logic                             decomp_raw;
    logic                             rdfifo_empty;
    logic [DW-1:0]                    rd_data;
    logic                             rd_valid;
    logic                             wrfifo_full;
    logic [`SIZE_WIDTH-1:0]           comp_size;
    logic                             comp_done;
    logic                             decomp_done;
    logic                             incompressible;
    logic                             rready;
    logic                             ld_rdfifo_rdptr;
    logic                             wr_req;
    logic [DW-1:0]                    wr_data;
    comdecomp_pkg::debug_compressor   debug_comp;
    comdecomp_pkg::debug_decompressor debug_decomp;
    comdecomp_pkg::debug_compressor   smp_dbg_comp;
    comdecomp_pkg::debug_decompressor smp_dbg_decomp;

    // read FIFO contents, captured write FIFO beats and the reference stream
    logic [DW-1:0] page [PB];
    logic [DW-1:0] src [MAX_BEATS];
    logic [DW-1:0] out_buf [MAX_BEATS];
    logic [DW-1:0] exp_buf [MAX_BEATS];
    logic [DW-1:0] sparse_stream [MAX_BEATS];
    logic [DW-1:0] dense_stream [MAX_BEATS];
    logic [PB-1:0] exp_bitmap;
    int            exp_nz;
    int            src_len;
    int            rd_ptr;
    int            out_len;
    int            exp_len;
    int            sparse_len;
    int            dense_len;
    logic          exp_incomp;
    logic          stall_en;
    logic          stall_rd;
    logic          stall_wr;
    logic [31:0]   rng;
    logic          saw_comp_done;
    logic          saw_decomp_done;
    logic          smp_incomp;
    int            smp_size;
    int            cycles;
    int            checks;
    int            errors;

    comdecomp_unit i_comdecomp_unit (.*);

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // never zero, differs for every beat index
    function automatic logic [DW-1:0] beat_value(input int idx);
        return {32'hc0de_0000 | 32'(idx), (32'(idx) * 32'h0101_0101) ^ 32'h5a5a_5a5a};
    endfunction

    task automatic check_value(input string name, input logic [DW-1:0] exp,
                               input logic [DW-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s expected 0x%0h got 0x%0h", name, exp, got);
        end
    endtask

    // show-ahead read FIFO and write FIFO status for the coming cycle
    task automatic drive_fifo();
        if (stall_en) begin
            rng      = xorshift(rng);
            stall_rd = (rng[1:0] == 2'b00);
            stall_wr = (rng[9:8] == 2'b00);
        end else begin
            stall_rd = 1'b0;
            stall_wr = 1'b0;
        end
        rdfifo_empty = (rd_ptr >= src_len) || stall_rd;
        rd_valid     = !rdfifo_empty;
        rd_data      = (rd_ptr < src_len) ? src[rd_ptr] : '0;
        wrfifo_full  = stall_wr;
    endtask

    // one clock cycle, outputs sampled mid-cycle and acted on at the edge
    task automatic step();
        logic          take;
        logic          rewind;
        logic          put;
        logic [DW-1:0] put_data;
        @(negedge clk_i);
        take            = rready;
        rewind          = ld_rdfifo_rdptr;
        put             = wr_req;
        put_data        = wr_data;
        saw_comp_done   = comp_done;
        saw_decomp_done = decomp_done;
        // status and debug outputs as seen in the done cycle
        if (comp_done) begin
            smp_size     = int'(comp_size);
            smp_incomp   = incompressible;
            smp_dbg_comp = debug_comp;
        end
        if (decomp_done) begin
            smp_dbg_decomp = debug_decomp;
        end
        @(posedge clk_i);
        cycles++;
        if (take && rdfifo_empty) begin
            errors++;
            $display("rready raised while the read FIFO was empty, cycle %0d", cycles);
        end
        if (put && wrfifo_full) begin
            errors++;
            $display("wr_req raised while the write FIFO was full, cycle %0d", cycles);
        end
        if (rewind) begin
            rd_ptr = 0;
        end else if (take) begin
            rd_ptr++;
        end
        if (put) begin
            if (out_len < MAX_BEATS) begin
                out_buf[out_len] = put_data;
            end
            out_len++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, checks %0d errors %0d", cycles, checks, errors);
            $display("*** FAILED ***");
            $finish;
        end
        #1;
        drive_fifo();
    endtask

    task automatic start_source(input int len);
        for (int i = 0; i < MAX_BEATS; i++) begin
            out_buf[i] = 'x;
        end
        rd_ptr  = 0;
        src_len = len;
        out_len = 0;
        drive_fifo();
    endtask

    // header of non-zero bitmap then the non-zero beats, or the raw page
    task automatic build_expected();
        logic [PB-1:0] bitmap;
        int            nz;
        bitmap = '0;
        nz     = 0;
        for (int i = 0; i < PB; i++) begin
            if (page[i] != '0) begin
                bitmap = bitmap | (PB'(1) << i);
                nz++;
            end
        end
        exp_bitmap = bitmap;
        exp_nz     = nz;
        exp_incomp = (nz > `COMP_LIMIT);
        exp_len    = 0;
        if (!exp_incomp) begin
            exp_buf[0] = DW'(bitmap);
            exp_len    = 1;
        end
        for (int i = 0; i < PB; i++) begin
            if (exp_incomp || page[i] != '0) begin
                exp_buf[exp_len] = page[i];
                exp_len++;
            end
        end
    endtask

    task automatic run_compress(input logic stalls);
        build_expected();
        for (int i = 0; i < PB; i++) begin
            src[i] = page[i];
        end
        stall_en = stalls;
        start_source(PB);
        comp_start    = 1'b1;
        saw_comp_done = 1'b0;
        while (!saw_comp_done) begin
            step();
        end
        comp_start = 1'b0;
        stall_en   = 1'b0;
        step();
        check_value("incompressible", DW'(exp_incomp), DW'(smp_incomp));
        check_value("comp_size", DW'(exp_len * `BEAT_BYTES), DW'(smp_size));
        check_value("incompressible held", DW'(exp_incomp), DW'(incompressible));
        check_value("comp_size held", DW'(exp_len * `BEAT_BYTES), DW'(comp_size));
        check_value("wr_req count", DW'(exp_len), DW'(out_len));
        for (int i = 0; i < exp_len; i++) begin
            check_value($sformatf("wr_data[%0d]", i), exp_buf[i], out_buf[i]);
        end
        check_value("rd pointer", DW'(PB), DW'(rd_ptr));
        check_value("debug_comp.state", DW'(comdecomp_pkg::COMP_DONE),
                    DW'(smp_dbg_comp.state));
        check_value("debug_comp.nz_count", DW'(exp_nz), DW'(smp_dbg_comp.nz_count));
        check_value("debug_comp.bitmap", DW'(exp_bitmap), DW'(smp_dbg_comp.bitmap));
    endtask

    // src holds the stream, page holds the page it must rebuild
    task automatic run_decompress(input logic raw, input int len);
        build_expected();
        stall_en = 1'b0;
        start_source(len);
        decomp_raw      = raw;
        decomp_start    = 1'b1;
        saw_decomp_done = 1'b0;
        while (!saw_decomp_done) begin
            step();
        end
        decomp_start = 1'b0;
        step();
        decomp_raw = 1'b0;
        check_value("wr_req count", DW'(PB), DW'(out_len));
        for (int i = 0; i < PB; i++) begin
            check_value($sformatf("wr_data[%0d]", i), page[i], out_buf[i]);
        end
        check_value("rd pointer", DW'(len), DW'(rd_ptr));
        check_value("debug_decomp.state", DW'(comdecomp_pkg::DECOMP_DONE),
                    DW'(smp_dbg_decomp.state));
        // a raw stream has no header, so no bitmap is loaded
        if (!raw) begin
            check_value("debug_decomp.bitmap", DW'(exp_bitmap),
                        DW'(smp_dbg_decomp.bitmap));
        end
    endtask

    task automatic fill_sparse();
        for (int i = 0; i < PB; i++) begin
            page[i] = (i % 3 == 1 || i == 12) ? beat_value(i) : '0;
        end
    endtask

    // 13 non-zero beats, one above the compression limit
    task automatic fill_dense();
        for (int i = 0; i < PB; i++) begin
            page[i] = (i == 2 || i == 8 || i == 14) ? '0 : beat_value(i);
        end
    endtask

    task automatic test_zero_page();
        for (int i = 0; i < PB; i++) begin
            page[i] = '0;
        end
        run_compress(1'b0);
        check_value("zero page beats", DW'(1), DW'(out_len));
    endtask

    task automatic test_sparse_page();
        fill_sparse();
        run_compress(1'b0);
        sparse_len = (out_len < MAX_BEATS) ? out_len : MAX_BEATS;
        for (int i = 0; i < sparse_len; i++) begin
            sparse_stream[i] = out_buf[i];
        end
    endtask

    task automatic test_dense_page();
        fill_dense();
        run_compress(1'b0);
        dense_len = (out_len < MAX_BEATS) ? out_len : MAX_BEATS;
        for (int i = 0; i < dense_len; i++) begin
            dense_stream[i] = out_buf[i];
        end
    endtask

    task automatic test_sparse_backpressure();
        fill_sparse();
        run_compress(1'b1);
    endtask

    task automatic test_decompress();
        fill_sparse();
        for (int i = 0; i < sparse_len; i++) begin
            src[i] = sparse_stream[i];
        end
        run_decompress(1'b0, sparse_len);
        fill_dense();
        for (int i = 0; i < dense_len; i++) begin
            src[i] = dense_stream[i];
        end
        run_decompress(1'b1, dense_len);
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        comp_start   = 1'b0;
        decomp_start = 1'b0;
        decomp_raw   = 1'b0;
        rdfifo_empty = 1'b1;
        rd_valid     = 1'b0;
        rd_data      = '0;
        wrfifo_full  = 1'b0;
        rng          = 32'hcac13657;
        stall_en     = 1'b0;
        stall_rd     = 1'b0;
        stall_wr     = 1'b0;
        src_len      = 0;
        rd_ptr       = 0;
        out_len      = 0;
        sparse_len   = 0;
        dense_len    = 0;
        cycles       = 0;
        checks       = 0;
        errors       = 0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        step();
        checks++;
        if (rready || ld_rdfifo_rdptr || wr_req || comp_done || decomp_done ||
            incompressible) begin
            errors++;
            $display("control outputs are not all low after reset");
        end
        test_zero_page();
        test_sparse_page();
        test_dense_page();
        test_sparse_backpressure();
        test_decompress();
        $display("checks %0d errors %0d cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/comdecomp_pkg.sv
verilog/comdecomp_if.sv
verilog/page_compressor.sv
verilog/page_decompressor.sv
verilog/comdecomp_unit.sv
sim/tb_comdecomp.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_comdecomp -f tb.f -Mdir obj_dir -o tb_comdecomp
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_comdecomp > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

exit 0
